//--- vlog.f
hw/cache_pkg.sv
hw/cache_arrays.sv
hw/cache_ctrl.sv
hw/banked_mem.sv
hw/cache_top.sv
verification/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := cache_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/cache_tb.sv
/*
 * cache testbench
 * table driven reads and writes against a word memory model and a
 * tag model, checks data, hit, stall and hit latency
 */
`default_nettype none

module cache_tb;

    localparam int DONE_TIMEOUT = 200;
    localparam int RANDOM_COUNT = 40;

    typedef struct {
        string             name;
        bit                wr;
        cache_pkg::addr_t  addr;
        cache_pkg::word_t  wdata;
        bit                exp_hit;
    } stim_t;

    logic                clk = 1'b0;
    logic                arst_n;
    cache_pkg::cpu_req_t cpu_req;
    cache_pkg::word_t    rdata;
    logic                done;
    logic                hit;
    logic                stall;

    stim_t stim_q[$];

    // word memory model keyed by word address
    // missing words read as zero
    cache_pkg::word_t mem_model[int];
    // tag and valid model for hit prediction
    cache_pkg::tag_t  tag_model[2 ** cache_pkg::INDEX_W];
    bit               valid_model[2 ** cache_pkg::INDEX_W];

    int data_errors  = 0;
    int hit_errors   = 0;
    int stall_errors = 0;
    int time_errors  = 0;
    int table_errors = 0;
    int timeouts     = 0;

    cache_top #(
        .MEM_LATENCY(4)
    ) u_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .cpu_req(cpu_req),
        .rdata  (rdata),
        .done   (done),
        .hit    (hit),
        .stall  (stall)
    );

    // period 8
    always #4 clk = ~clk;

    // tag, index, word, then a zero byte bit
    function automatic cache_pkg::addr_t make_addr(input int tag, input int index,
                                                   input int word);
        return {cache_pkg::tag_t'(tag), cache_pkg::index_t'(index), 2'(word), 1'b0};
    endfunction

    // predicts a hit and allocates the line either way
    function automatic bit predict_hit(input cache_pkg::addr_t addr);
        cache_pkg::tag_t   tag;
        cache_pkg::index_t index;
        bit                result;
        tag   = addr[15 -: cache_pkg::TAG_W];
        index = addr[3 +: cache_pkg::INDEX_W];
        result = valid_model[index] && (tag_model[index] == tag);
        valid_model[index] = 1'b1;
        tag_model[index]   = tag;
        return result;
    endfunction

    function automatic void add_entry(input string name, input bit wr,
                                      input cache_pkg::addr_t addr,
                                      input cache_pkg::word_t wdata, input bit exp_hit);
        stim_t s;
        bit    predicted;
        s = '{name: name, wr: wr, addr: addr, wdata: wdata, exp_hit: exp_hit};
        predicted = predict_hit(addr);
        // hand written hit flags must agree with the tag model
        assert (predicted == exp_hit) else begin
            table_errors++;
            $display("stimulus table hit flag for %s disagrees with the tag model", name);
        end
        stim_q.push_back(s);
    endfunction

    function automatic void build_table();
        cache_pkg::addr_t addr;
        stim_t            s;
        for (int i = 0; i < 2 ** cache_pkg::INDEX_W; i++) begin
            valid_model[i] = 1'b0;
            tag_model[i]   = '0;
        end
        // cold read and refill
        add_entry("cold_rd",       1'b0, make_addr(1, 'h10, 2), 16'h0000, 1'b0);
        add_entry("cold_rd_again", 1'b0, make_addr(1, 'h10, 2), 16'h0000, 1'b1);
        // write allocate
        add_entry("wr_miss",       1'b1, make_addr(2, 'h20, 1), 16'ha5c3, 1'b0);
        add_entry("rd_after_wr",   1'b0, make_addr(2, 'h20, 1), 16'h0000, 1'b1);
        // neighbours in the same line
        add_entry("wr_hit_w0",     1'b1, make_addr(2, 'h20, 0), 16'h1111, 1'b1);
        add_entry("wr_hit_w3",     1'b1, make_addr(2, 'h20, 3), 16'h3333, 1'b1);
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            add_entry($sformatf("rd_line_w%0d", w), 1'b0, make_addr(2, 'h20, w), 16'h0000, 1'b1);
        end
        // dirty victim goes back to memory
        add_entry("evict_wr",      1'b1, make_addr(7, 'h20, 1), 16'hbeef, 1'b0);
        add_entry("rd_old",        1'b0, make_addr(2, 'h20, 1), 16'h0000, 1'b0);
        add_entry("rd_old_w3",     1'b0, make_addr(2, 'h20, 3), 16'h0000, 1'b1);
        add_entry("rd_new",        1'b0, make_addr(7, 'h20, 1), 16'h0000, 1'b0);
        // random mix over few indices and tags so lines collide
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            addr = make_addr(1 + int'($urandom % 3), 'h20 + int'($urandom % 3),
                             int'($urandom % 4));
            s.name    = $sformatf("rand_%0d", i);
            s.wr      = 1'($urandom % 2);
            s.addr    = addr;
            s.wdata   = 16'($urandom);
            // hit flag straight from the tag model
            s.exp_hit = predict_hit(addr);
            stim_q.push_back(s);
        end
    endfunction

    // sampled at the falling edge
    // stall mirrors done while a request waits
    task automatic wait_done(input string name, output bit ok, output int cycles);
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            assert (stall === !done) else begin
                stall_errors++;
                $display("Fail %s stall expected %b actual %b", name, !done, stall);
            end
            if (done === 1'b1) begin
                ok = 1'b1;
            end else begin
                cycles++;
            end
        end
    endtask

    task automatic check_result(input stim_t s, input int cycles);
        cache_pkg::word_t exp_data;
        int               key;
        key      = int'(s.addr[15:1]);
        exp_data = mem_model.exists(key) ? mem_model[key] : '0;
        if (!s.wr) begin
            assert (rdata === exp_data) else begin
                data_errors++;
                $display("Fail %s rdata expected %h actual %h", s.name, exp_data, rdata);
            end
        end else begin
            mem_model[key] = s.wdata;
        end
        assert (hit === s.exp_hit) else begin
            hit_errors++;
            $display("Fail %s hit expected %b actual %b", s.name, s.exp_hit, hit);
        end
        // read hit done in the request cycle
        // write hit done one cycle later
        if (s.exp_hit) begin
            assert (cycles == (s.wr ? 1 : 0)) else begin
                time_errors++;
                $display("Fail %s hit latency expected %0d actual %0d",
                         s.name, s.wr ? 1 : 0, cycles);
            end
        end
    endtask

    initial begin
        cache_pkg::cpu_req_t req;
        bit                  ok;
        int                  cycles;
        void'($urandom(32'h2594));
        arst_n  = 1'b0;
        cpu_req = '0;
        build_table();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (!done && !hit && !stall) else begin
            time_errors++;
            $display("done, hit or stall is high after reset with no request");
        end
        ok = 1'b1;
        for (int i = 0; i < stim_q.size() && ok; i++) begin
            @(posedge clk);
            req       = '0;
            req.rd    = !stim_q[i].wr;
            req.wr    = stim_q[i].wr;
            req.addr  = stim_q[i].addr;
            req.wdata = stim_q[i].wdata;
            cpu_req <= req;
            wait_done(stim_q[i].name, ok, cycles);
            if (ok) begin
                check_result(stim_q[i], cycles);
            end else begin
                timeouts++;
                $display("timeout: %s got no done within %0d cycles",
                         stim_q[i].name, DONE_TIMEOUT);
            end
        end
        @(posedge clk);
        cpu_req <= '0;
        $display("errors: data %0d, hit %0d, stall %0d, timing %0d, table %0d, timeout %0d",
                 data_errors, hit_errors, stall_errors, time_errors, table_errors, timeouts);
        if (data_errors + hit_errors + stall_errors + time_errors
            + table_errors + timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/cache_top.sv
/*
 * cache top level
 * controller, line arrays and banked main memory
 */
`default_nettype none

module cache_top #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::word_t    rdata,
    output logic                done,
    output logic                hit,
    output logic                stall
);

    // controller to arrays
    cache_pkg::line_meta_t line_meta;
    cache_pkg::word_t      line_word;
    cache_pkg::array_wr_t  array_wr;
    cache_pkg::index_t     lookup_index;
    cache_pkg::word_sel_t  lookup_word;

    // controller to memory
    cache_pkg::mem_req_t                  mem_req;
    cache_pkg::word_t                     mem_rdata;
    logic                                 mem_rvalid;
    logic [cache_pkg::WORDS_PER_LINE-1:0] mem_busy;

    cache_ctrl #(
        .MEM_LATENCY(MEM_LATENCY)
    ) u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .cpu_req     (cpu_req),
        .line_meta   (line_meta),
        .line_word   (line_word),
        .array_wr    (array_wr),
        .lookup_index(lookup_index),
        .lookup_word (lookup_word),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_busy    (mem_busy),
        .rdata       (rdata),
        .done        (done),
        .hit         (hit),
        .stall       (stall)
    );

    cache_arrays u_arrays (
        .clk         (clk),
        .arst_n      (arst_n),
        .lookup_index(lookup_index),
        .lookup_word (lookup_word),
        .array_wr    (array_wr),
        .line_meta   (line_meta),
        .line_word   (line_word)
    );

    banked_mem #(
        .MEM_LATENCY(MEM_LATENCY)
    ) u_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_rvalid(mem_rvalid),
        .mem_busy  (mem_busy)
    );

endmodule

`default_nettype wire

//--- hw/banked_mem.sv
/*
 * four bank main memory
 * bank chosen by the word select bits, fixed access latency,
 * read data returned in issue order through a delay line
 */
`default_nettype none

module banked_mem #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  cache_pkg::mem_req_t                  mem_req,
    output cache_pkg::word_t                     mem_rdata,
    output logic                                 mem_rvalid,
    output logic [cache_pkg::WORDS_PER_LINE-1:0] mem_busy
);

    localparam int SEL_W  = $bits(cache_pkg::word_sel_t);
    localparam int ROW_W  = cache_pkg::TAG_W + cache_pkg::INDEX_W;
    localparam int ROWS   = 2 ** ROW_W;
    localparam int BYTE_W = $bits(cache_pkg::addr_t) - ROW_W - SEL_W;
    localparam int CNT_W  = $clog2(MEM_LATENCY + 1);

    cache_pkg::word_t bank_mem[cache_pkg::WORDS_PER_LINE][ROWS];

    // per bank busy countdown
    logic [CNT_W-1:0] busy_cnt_q[cache_pkg::WORDS_PER_LINE];

    // read return delay line
    cache_pkg::word_t       pipe_data[MEM_LATENCY];
    logic [MEM_LATENCY-1:0] pipe_valid;

    cache_pkg::word_sel_t req_bank;
    logic [ROW_W-1:0]     req_row;

    assign req_bank = mem_req.addr[BYTE_W +: SEL_W];
    assign req_row  = mem_req.addr[BYTE_W + SEL_W +: ROW_W];

    always_comb begin
        for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
            mem_busy[b] = (busy_cnt_q[b] != '0);
        end
    end

    assign mem_rdata  = pipe_data[MEM_LATENCY-1];
    assign mem_rvalid = pipe_valid[MEM_LATENCY-1];

    // storage, zero after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
                for (int r = 0; r < ROWS; r++) begin
                    bank_mem[b][r] <= '0;
                end
            end
        end else if (mem_req.wr) begin
            bank_mem[req_bank][req_row] <= mem_req.wdata;
        end
    end

    // a strobe reloads the bank count, otherwise count down to idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
                busy_cnt_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
                if ((mem_req.rd || mem_req.wr) && req_bank == cache_pkg::word_sel_t'(b)) begin
                    busy_cnt_q[b] <= CNT_W'(MEM_LATENCY);
                end else if (busy_cnt_q[b] != '0) begin
                    busy_cnt_q[b] <= busy_cnt_q[b] - 1'b1;
                end
            end
        end
    end

    // data sampled at the strobe, shifted out after the latency
    always_ff @(posedge clk) begin
        pipe_data[0] <= bank_mem[req_bank][req_row];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= mem_req.rd;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
        end
    end

    // controller must wait for a free bank
    a_bank_free: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req.rd || mem_req.wr) |-> !mem_busy[req_bank])
        else $error("strobe to busy bank");

endmodule

`default_nettype wire

//--- hw/cache_ctrl.sv
/*
 * cache controller
 * hit detection, dirty victim write-back, line refill and
 * write allocate, sequenced by one FSM with word counters
 */
`default_nettype none

module cache_ctrl #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  cache_pkg::cpu_req_t                  cpu_req,
    input  cache_pkg::line_meta_t                line_meta,
    input  cache_pkg::word_t                     line_word,
    output cache_pkg::array_wr_t                 array_wr,
    output cache_pkg::index_t                    lookup_index,
    output cache_pkg::word_sel_t                 lookup_word,
    output cache_pkg::mem_req_t                  mem_req,
    input  cache_pkg::word_t                     mem_rdata,
    input  logic                                 mem_rvalid,
    input  logic [cache_pkg::WORDS_PER_LINE-1:0] mem_busy,
    output cache_pkg::word_t                     rdata,
    output logic                                 done,
    output logic                                 hit,
    output logic                                 stall
);

    localparam int ADDR_W   = $bits(cache_pkg::addr_t);
    localparam int SEL_W    = $bits(cache_pkg::word_sel_t);
    localparam int OFFSET_W = ADDR_W - cache_pkg::TAG_W - cache_pkg::INDEX_W;
    // byte bits below the word select
    localparam int BYTE_W   = OFFSET_W - SEL_W;
    localparam cache_pkg::word_sel_t LAST_WORD =
        cache_pkg::word_sel_t'(cache_pkg::WORDS_PER_LINE - 1);

    cache_pkg::ctrl_state_t state_q, state_d;
    cache_pkg::word_sel_t   issue_cnt_q, issue_cnt_d;
    cache_pkg::word_sel_t   ret_cnt_q, ret_cnt_d;

    cache_pkg::tag_t      req_tag;
    cache_pkg::index_t    req_index;
    cache_pkg::word_sel_t req_word;
    logic                 req_valid;
    logic                 tag_match;
    logic                 victim_dirty;

    // request address fields
    assign req_tag   = cpu_req.addr[ADDR_W-1 -: cache_pkg::TAG_W];
    assign req_index = cpu_req.addr[OFFSET_W +: cache_pkg::INDEX_W];
    assign req_word  = cpu_req.addr[BYTE_W +: SEL_W];
    assign req_valid = cpu_req.rd | cpu_req.wr;

    assign tag_match    = line_meta.valid && (line_meta.tag == req_tag);
    assign victim_dirty = line_meta.valid && line_meta.dirty;

    assign lookup_index = req_index;
    // addressed word, only meaningful with done
    assign rdata        = line_word;
    assign stall        = req_valid & ~done;

    always_comb begin
        state_d     = state_q;
        issue_cnt_d = issue_cnt_q;
        ret_cnt_d   = ret_cnt_q;
        lookup_word = req_word;
        done        = 1'b0;
        hit         = 1'b0;

        // default array update is the processor write, disabled
        array_wr            = '0;
        array_wr.index      = req_index;
        array_wr.word       = req_word;
        array_wr.data       = cpu_req.wdata;
        array_wr.meta.tag   = req_tag;
        array_wr.meta.valid = 1'b1;
        array_wr.meta.dirty = 1'b1;

        mem_req      = '0;
        mem_req.addr = cpu_req.addr;

        // refill words land in the line as they return
        if ((state_q == cache_pkg::FILL_ISSUE || state_q == cache_pkg::FILL_WAIT)
            && mem_rvalid) begin
            array_wr.en         = 1'b1;
            array_wr.word       = ret_cnt_q;
            array_wr.data       = mem_rdata;
            array_wr.set_meta   = 1'b1;
            array_wr.meta.dirty = 1'b0;
            ret_cnt_d           = ret_cnt_q + 1'b1;
        end

        case (state_q)
            cache_pkg::IDLE: begin
                // read hit finishes with no extra cycle
                if (cpu_req.rd) begin
                    if (tag_match) begin
                        done = 1'b1;
                        hit  = 1'b1;
                    end else begin
                        state_d = cache_pkg::MISS_CHECK;
                    end
                end else if (cpu_req.wr) begin
                    state_d = cache_pkg::WR_CHECK;
                end
            end
            cache_pkg::WR_CHECK: begin
                if (tag_match) begin
                    array_wr.en       = 1'b1;
                    array_wr.set_meta = 1'b1;
                    done              = 1'b1;
                    hit               = 1'b1;
                    state_d           = cache_pkg::IDLE;
                end else begin
                    // write miss, this cycle doubles as the victim check
                    state_d = victim_dirty ? cache_pkg::WB_ISSUE : cache_pkg::FILL_ISSUE;
                end
            end
            cache_pkg::MISS_CHECK: begin
                state_d = victim_dirty ? cache_pkg::WB_ISSUE : cache_pkg::FILL_ISSUE;
            end
            cache_pkg::WB_ISSUE: begin
                // victim word k goes to bank k under the stored tag
                lookup_word = issue_cnt_q;
                if (!mem_busy[issue_cnt_q]) begin
                    mem_req.wr    = 1'b1;
                    mem_req.addr  = {line_meta.tag, req_index, issue_cnt_q, {BYTE_W{1'b0}}};
                    mem_req.wdata = line_word;
                    issue_cnt_d   = issue_cnt_q + 1'b1;
                    if (issue_cnt_q == LAST_WORD) begin
                        state_d = cache_pkg::WB_DRAIN;
                    end
                end
            end
            cache_pkg::WB_DRAIN: begin
                if (mem_busy == '0) begin
                    state_d = cache_pkg::FILL_ISSUE;
                end
            end
            cache_pkg::FILL_ISSUE: begin
                if (!mem_busy[issue_cnt_q]) begin
                    mem_req.rd   = 1'b1;
                    mem_req.addr = {req_tag, req_index, issue_cnt_q, {BYTE_W{1'b0}}};
                    issue_cnt_d  = issue_cnt_q + 1'b1;
                    if (issue_cnt_q == LAST_WORD) begin
                        state_d = cache_pkg::FILL_WAIT;
                    end
                end
            end
            cache_pkg::FILL_WAIT: begin
                // last return closes the refill
                if (mem_rvalid && ret_cnt_q == LAST_WORD) begin
                    state_d = cpu_req.wr ? cache_pkg::WR_ALLOC : cache_pkg::RD_FINISH;
                end
            end
            cache_pkg::WR_ALLOC: begin
                // line is clean and resident, now merge the write
                array_wr.en       = 1'b1;
                array_wr.set_meta = 1'b1;
                done              = 1'b1;
                state_d           = cache_pkg::IDLE;
            end
            cache_pkg::RD_FINISH: begin
                done    = 1'b1;
                state_d = cache_pkg::IDLE;
            end
            default: begin
                state_d = cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= cache_pkg::IDLE;
            issue_cnt_q <= '0;
            ret_cnt_q   <= '0;
        end else begin
            state_q     <= state_d;
            issue_cnt_q <= issue_cnt_d;
            ret_cnt_q   <= ret_cnt_d;
        end
    end

    // memory sees one kind of strobe per cycle
    a_mem_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_req.rd && mem_req.wr))
        else $error("mem rd and wr together");

    // completion only for a live request
    a_done_req: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> req_valid)
        else $error("done without request");

    // fixed latency bounds the wait after the last fill strobe
    a_fill_bound: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(state_q == cache_pkg::FILL_WAIT)
        |-> ##[1:MEM_LATENCY] (state_q != cache_pkg::FILL_WAIT))
        else $error("refill wait exceeds memory latency");

endmodule

`default_nettype wire

//--- hw/cache_arrays.sv
/*
 * direct mapped cache storage
 * tag, valid and dirty per line plus four data words per line,
 * combinational lookup and single word update on the clock edge
 */
`default_nettype none

module cache_arrays (
    input  logic                  clk,
    input  logic                  arst_n,
    input  cache_pkg::index_t     lookup_index,
    input  cache_pkg::word_sel_t  lookup_word,
    input  cache_pkg::array_wr_t  array_wr,
    output cache_pkg::line_meta_t line_meta,
    output cache_pkg::word_t      line_word
);

    localparam int NUM_LINES = 2 ** cache_pkg::INDEX_W;

    // line payload and tags
    cache_pkg::word_t data_mem [NUM_LINES][cache_pkg::WORDS_PER_LINE];
    cache_pkg::tag_t  tag_mem  [NUM_LINES];
    logic             dirty_mem[NUM_LINES];

    // valid bits, the only state cleared by reset
    logic [NUM_LINES-1:0] valid_q;

    logic meta_we;

    // metadata only moves together with a word write
    assign meta_we = array_wr.en && array_wr.set_meta;

    // lookup path
    assign line_meta.tag   = tag_mem[lookup_index];
    assign line_meta.valid = valid_q[lookup_index];
    assign line_meta.dirty = dirty_mem[lookup_index];
    assign line_word       = data_mem[lookup_index][lookup_word];

    // word update
    always_ff @(posedge clk) begin
        if (array_wr.en) begin
            data_mem[array_wr.index][array_wr.word] <= array_wr.data;
        end
    end

    // tag and dirty update
    always_ff @(posedge clk) begin
        if (meta_we) begin
            tag_mem[array_wr.index]   <= array_wr.meta.tag;
            dirty_mem[array_wr.index] <= array_wr.meta.dirty;
        end
    end

    // valid per line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (meta_we) begin
            valid_q[array_wr.index] <= array_wr.meta.valid;
        end
    end

endmodule

`default_nettype wire

//--- hw/cache_pkg.sv
/*
 * cache shared definitions
 * address split, data types, controller states and the request
 * bundles exchanged between controller, arrays and banked memory
 */
`default_nettype none

package cache_pkg;

    // address split 5 / 8 / 3
    localparam int TAG_W          = 5;
    localparam int INDEX_W        = 8;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [15:0]                         addr_t;
    typedef logic [15:0]                         word_t;
    typedef logic [TAG_W-1:0]                    tag_t;
    typedef logic [INDEX_W-1:0]                  index_t;
    // word within a line, also the bank number
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]   word_sel_t;

    typedef enum logic [3:0] {
        IDLE,
        WR_CHECK,
        MISS_CHECK,
        WB_ISSUE,
        WB_DRAIN,
        FILL_ISSUE,
        FILL_WAIT,
        WR_ALLOC,
        RD_FINISH
    } ctrl_state_t;

    // processor request, rd and wr never together
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    // single word memory access, one cycle strobe
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
        logic dirty;
    } line_meta_t;

    // one word write, metadata optional
    typedef struct packed {
        logic       en;
        index_t     index;
        word_sel_t  word;
        word_t      data;
        logic       set_meta;
        line_meta_t meta;
    } array_wr_t;

endpackage

`default_nettype wire
